/* Makefile */
TOP = tb_gfx_fade_display

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* src/fade_stage.sv */
module fade_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            fade_valid,
  input  fb_pkg::wr_req_t fade_req,
  input  logic            fade_pop,
  output logic            fade_pending,
  output fb_pkg::wr_req_t fade_head
);

  localparam int DEPTH = 4;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CB    = fb_pkg::CHAN_BITS;

  logic                          in_valid;
  fb_pkg::wr_req_t               in_req;
  fb_pkg::wr_req_t               aged;
  logic [fb_pkg::PIXEL_BITS-1:0] halved;

  fb_pkg::wr_req_t q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_valid <= 1'b0;
    end else begin
      in_valid <= fade_valid;
    end
  end

  always_ff @(posedge clk) begin
    in_req <= fade_req;
  end

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      halved[c*CB +: CB] = in_req.pix.color[c*CB +: CB] >> 1;
    end
  end

  // one step older, dimmer at HALVE_AGE, dark at zero
  always_comb begin
    aged.addr    = in_req.addr;
    aged.pix.age = (in_req.pix.age != '0) ? in_req.pix.age - 1'b1 : '0;
    if (aged.pix.age == '0) begin
      aged.pix.color = '0;
    end else if (aged.pix.age == fb_pkg::HALVE_AGE) begin
      aged.pix.color = halved;
    end else begin
      aged.pix.color = in_req.pix.color;
    end
  end

  assign full         = count == (PTR_W + 1)'(DEPTH);
  assign fade_pending = count != '0;
  assign fade_head    = q[rd_ptr];

  always_ff @(posedge clk) begin
    if (in_valid) begin
      q[wr_ptr] <= aged;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fade_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({in_valid, fade_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // fade writes outrank drawing, so the queue drains faster than scanout fills it
  a_no_push_full : assert property (@(posedge clk) disable iff (rst)
    in_valid |-> !full);
  a_no_pop_empty : assert property (@(posedge clk) disable iff (rst)
    fade_pop |-> fade_pending);

endmodule

/* src/fb_pkg.sv */
package fb_pkg;

  // drawing coordinates
  localparam int X_BITS = 4;
  localparam int Y_BITS = 3;

  // one address per pixel, 256 pixels
  localparam int ADDR_BITS = 8;

  // color is red, green, blue with red in the top bits
  localparam int CHAN_BITS  = 4;
  localparam int PIXEL_BITS = 3 * CHAN_BITS;

  localparam int AGE_BITS = 4;

  // age stored by a drawing write
  localparam logic [AGE_BITS-1:0] NEW_AGE = 4'd4;
  // new age at which every channel gets halved
  localparam logic [AGE_BITS-1:0] HALVE_AGE = 4'd2;

  typedef struct packed {
    logic [AGE_BITS-1:0]   age;
    logic [PIXEL_BITS-1:0] color;
  } pix_t;

  typedef struct packed {
    logic [X_BITS-1:0]     x;
    logic [Y_BITS-1:0]     y;
    logic [PIXEL_BITS-1:0] color;
  } gfx_cmd_t;

  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    pix_t                 pix;
  } wr_req_t;

  // syncs are active low
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic visible;
  } scan_t;

  typedef enum logic [1:0] {
    grant_none,
    grant_fade,
    grant_gfx
  } grant_t;

endpackage

/* src/fb_write_arbiter.sv */
module fb_write_arbiter #(
  parameter int H_VISIBLE = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             gfx_valid,
  input  fb_pkg::gfx_cmd_t gfx_cmd,
  output logic             gfx_ready,
  input  logic             fade_pending,
  input  fb_pkg::wr_req_t  fade_head,
  output logic             fade_pop,
  output logic             wr_en,
  output fb_pkg::wr_req_t  wr
);

  localparam int AW = fb_pkg::ADDR_BITS;

  logic            gfx_en;
  fb_pkg::grant_t  grant;
  fb_pkg::wr_req_t gfx_wr;

  // drawing opens up one cycle after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      gfx_en <= 1'b0;
    end else begin
      gfx_en <= 1'b1;
    end
  end

  assign gfx_ready = gfx_en && !fade_pending;

  // fixed priority, fade first
  always_comb begin
    grant = fb_pkg::grant_none;
    if (fade_pending) begin
      grant = fb_pkg::grant_fade;
    end else if (gfx_valid && gfx_ready) begin
      grant = fb_pkg::grant_gfx;
    end
  end

  always_comb begin
    gfx_wr.addr      = AW'(int'(gfx_cmd.y) * H_VISIBLE + int'(gfx_cmd.x));
    gfx_wr.pix.age   = fb_pkg::NEW_AGE;
    gfx_wr.pix.color = gfx_cmd.color;
  end

  assign fade_pop = grant == fb_pkg::grant_fade;
  assign wr_en    = grant != fb_pkg::grant_none;
  assign wr       = fade_pop ? fade_head : gfx_wr;

endmodule

/* src/frame_buffer.sv */
module frame_buffer (
  input  logic                         clk,
  input  logic                         wr_en,
  input  fb_pkg::wr_req_t              wr,
  input  logic [fb_pkg::ADDR_BITS-1:0] rd_addr,
  output fb_pkg::pix_t                 rd_pix
);

  localparam int DEPTH = 2 ** fb_pkg::ADDR_BITS;

  fb_pkg::pix_t mem [DEPTH];

  // screen starts black with every pixel at age zero
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr.addr] <= wr.pix;
    end
  end

  // read data is valid one cycle after the address
  always_ff @(posedge clk) begin
    rd_pix <= mem[rd_addr];
  end

endmodule

/* src/gfx_fade_display.sv */
module gfx_fade_display #(
  parameter int H_VISIBLE = 8,
  parameter int H_FRONT   = 2,
  parameter int H_SYNC    = 2,
  parameter int H_BACK    = 2,
  parameter int V_VISIBLE = 4,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 1,
  parameter int V_BACK    = 1
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          gfx_valid,
  input  fb_pkg::gfx_cmd_t              gfx_cmd,
  output logic                          gfx_ready,
  input  logic                          vga_enable,
  output logic [fb_pkg::PIXEL_BITS-1:0] vga_color,
  output fb_pkg::scan_t                 vga_scan
);

  fb_pkg::scan_t                scan;
  logic [fb_pkg::ADDR_BITS-1:0] rd_addr;
  fb_pkg::pix_t                 rd_pix;
  logic                         fade_valid;
  fb_pkg::wr_req_t              fade_req;
  logic                         fade_pending;
  fb_pkg::wr_req_t              fade_head;
  logic                         fade_pop;
  logic                         wr_en;
  fb_pkg::wr_req_t              wr;

  raster_timing #(
    .H_VISIBLE(H_VISIBLE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_VISIBLE(V_VISIBLE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_raster_timing (
    .clk    (clk),
    .rst    (rst),
    .enable (vga_enable),
    .scan   (scan),
    .rd_addr(rd_addr)
  );

  frame_buffer u_frame_buffer (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr     (wr),
    .rd_addr(rd_addr),
    .rd_pix (rd_pix)
  );

  scanout u_scanout (
    .clk       (clk),
    .rst       (rst),
    .scan_in   (scan),
    .rd_addr   (rd_addr),
    .rd_pix    (rd_pix),
    .vga_color (vga_color),
    .vga_scan  (vga_scan),
    .fade_valid(fade_valid),
    .fade_req  (fade_req)
  );

  fade_stage u_fade_stage (
    .clk         (clk),
    .rst         (rst),
    .fade_valid  (fade_valid),
    .fade_req    (fade_req),
    .fade_pop    (fade_pop),
    .fade_pending(fade_pending),
    .fade_head   (fade_head)
  );

  fb_write_arbiter #(
    .H_VISIBLE(H_VISIBLE)
  ) u_fb_write_arbiter (
    .clk         (clk),
    .rst         (rst),
    .gfx_valid   (gfx_valid),
    .gfx_cmd     (gfx_cmd),
    .gfx_ready   (gfx_ready),
    .fade_pending(fade_pending),
    .fade_head   (fade_head),
    .fade_pop    (fade_pop),
    .wr_en       (wr_en),
    .wr          (wr)
  );

endmodule

/* src/raster_timing.sv */
module raster_timing #(
  parameter int H_VISIBLE = 8,
  parameter int H_FRONT   = 2,
  parameter int H_SYNC    = 2,
  parameter int H_BACK    = 2,
  parameter int V_VISIBLE = 4,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 1,
  parameter int V_BACK    = 1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  output fb_pkg::scan_t                scan,
  output logic [fb_pkg::ADDR_BITS-1:0] rd_addr
);

  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_W     = $clog2(H_TOTAL);
  localparam int V_W     = $clog2(V_TOTAL);
  localparam int AW      = fb_pkg::ADDR_BITS;

  logic [H_W-1:0] h_cnt;
  logic [V_W-1:0] v_cnt;
  logic           h_last;
  logic           v_last;

  assign h_last = int'(h_cnt) == H_TOTAL - 1;
  assign v_last = int'(v_cnt) == V_TOTAL - 1;

  // counters park at the top left corner while disabled
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!enable) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // sync pulse sits between the front and back porch
  assign scan.hsync = !((int'(h_cnt) >= H_VISIBLE + H_FRONT) &&
                        (int'(h_cnt) <  H_VISIBLE + H_FRONT + H_SYNC));
  assign scan.vsync = !((int'(v_cnt) >= V_VISIBLE + V_FRONT) &&
                        (int'(v_cnt) <  V_VISIBLE + V_FRONT + V_SYNC));
  assign scan.visible = enable && (int'(h_cnt) < H_VISIBLE) && (int'(v_cnt) < V_VISIBLE);

  assign rd_addr = AW'(int'(v_cnt) * H_VISIBLE + int'(h_cnt));

  // raster address never leaves the drawn area during visible pixels
  a_addr_in_range : assert property (@(posedge clk) disable iff (rst)
    scan.visible |-> int'(rd_addr) < H_VISIBLE * V_VISIBLE);

endmodule

/* src/scanout.sv */
module scanout (
  input  logic                          clk,
  input  logic                          rst,
  input  fb_pkg::scan_t                 scan_in,
  input  logic [fb_pkg::ADDR_BITS-1:0]  rd_addr,
  input  fb_pkg::pix_t                  rd_pix,
  output logic [fb_pkg::PIXEL_BITS-1:0] vga_color,
  output fb_pkg::scan_t                 vga_scan,
  output logic                          fade_valid,
  output fb_pkg::wr_req_t               fade_req
);

  localparam fb_pkg::scan_t SCAN_IDLE = '{hsync: 1'b1, vsync: 1'b1, visible: 1'b0};

  fb_pkg::scan_t                scan_d;
  logic [fb_pkg::ADDR_BITS-1:0] addr_d;
  logic                         candidate;

  // match the one cycle memory latency
  always_ff @(posedge clk) begin
    if (rst) begin
      scan_d <= SCAN_IDLE;
    end else begin
      scan_d <= scan_in;
    end
  end

  always_ff @(posedge clk) begin
    addr_d <= rd_addr;
  end

  // lit pixels with some age left go back for fading
  assign candidate = scan_d.visible && (|rd_pix.color) && (rd_pix.age != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_scan   <= SCAN_IDLE;
      vga_color  <= '0;
      fade_valid <= 1'b0;
    end else begin
      vga_scan   <= scan_d;
      vga_color  <= scan_d.visible ? rd_pix.color : '0;
      fade_valid <= candidate;
    end
  end

  always_ff @(posedge clk) begin
    fade_req.addr <= addr_d;
    fade_req.pix  <= rd_pix;
  end

endmodule

/* testbench/gfx_patterns.txt */
// columns: x y color, all hex, one pixel per line
// a later line at the same x and y overwrites the earlier one
0 0 fff
7 0 a5c
3 1 123
4 1 000
0 3 8e1
7 3 f0f
2 2 777
2 2 0c4
5 2 001
6 0 0f0

/* testbench/tb_fade_checker.sv */
module tb_fade_checker #(
  parameter int H_VISIBLE    = 8,
  parameter int V_VISIBLE    = 4,
  parameter int V_TOTAL      = 7,
  parameter int N_ENTRIES    = 10,
  parameter int FRAME_CYCLES = 98,
  parameter int N_FRAMES     = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          gfx_ready,
  input  logic [fb_pkg::PIXEL_BITS-1:0] vga_color,
  input  fb_pkg::scan_t                 vga_scan,
  output logic                          done,
  output int                            mismatches,
  output int                            failures
);

  localparam int N_PIX = H_VISIBLE * V_VISIBLE;

  logic [fb_pkg::PIXEL_BITS-1:0] patterns [3*N_ENTRIES];
  logic [fb_pkg::PIXEL_BITS-1:0] image [N_PIX];
  logic                          rst_q;

  // reset as the DUT saw it on the last rising edge
  always_ff @(posedge clk) begin
    rst_q <= rst;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
    mismatches++;
  endtask

  task automatic report_failure(input string what);
    $display("error: %s", what);
    failures++;
  endtask

  // each 4-bit channel shifted right by one
  function automatic logic [11:0] halve(input logic [11:0] c);
    return {1'b0, c[11:9], 1'b0, c[7:5], 1'b0, c[3:1]};
  endfunction

  // drawn at age 4, halved when the age reaches 2, dark at age 0
  function automatic logic [11:0] expected_color(input logic [11:0] c, input int frame);
    if (frame <= 2) begin
      return c;
    end else if (frame <= 4) begin
      return halve(c);
    end
    return '0;
  endfunction

  task automatic build_image();
    int idx;
    for (int i = 0; i < N_PIX; i++) begin
      image[i] = '0;
    end
    // later entries overwrite earlier ones
    for (int e = 0; e < N_ENTRIES; e++) begin
      idx = int'(patterns[3*e+1]) * H_VISIBLE + int'(patterns[3*e]);
      if (idx < N_PIX) begin
        image[idx] = patterns[3*e+2];
      end else begin
        report_failure($sformatf("pattern entry %0d lies outside the visible area", e));
      end
    end
  endtask

  task automatic check_reset();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rst_q === 1'b1 && cycles < 20) begin
      if (gfx_ready !== 1'b0) report_mismatch("reset_gfx_ready", 0, gfx_ready);
      if (vga_scan.visible !== 1'b0) report_mismatch("reset_visible", 0, vga_scan.visible);
      if (vga_scan.hsync !== 1'b1) report_mismatch("reset_hsync", 1, vga_scan.hsync);
      if (vga_scan.vsync !== 1'b1) report_mismatch("reset_vsync", 1, vga_scan.vsync);
      @(negedge clk);
      cycles++;
    end
    if (rst_q !== 1'b0) report_failure("reset was never released");
    cycles = 0;
    while (gfx_ready !== 1'b1 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (gfx_ready !== 1'b1) report_failure("timeout: gfx_ready never rose after reset");
  endtask

  // one frame ends at the falling edge of vsync
  task automatic check_frame(input int frame);
    int                            idx;
    int                            cycles;
    int                            hsync_falls;
    logic                          prev_vsync;
    logic                          prev_hsync;
    logic                          vsync_fell;
    logic [fb_pkg::PIXEL_BITS-1:0] exp;
    idx         = 0;
    cycles      = 0;
    hsync_falls = 0;
    prev_vsync  = vga_scan.vsync;
    prev_hsync  = vga_scan.hsync;
    vsync_fell  = 1'b0;
    while (!vsync_fell && cycles < 3 * FRAME_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (vga_scan.visible) begin
        if (idx < N_PIX) begin
          exp = expected_color(image[idx], frame);
          if (vga_color !== exp) begin
            report_mismatch($sformatf("frame%0d_x%0d_y%0d", frame, idx % H_VISIBLE,
                                      idx / H_VISIBLE), exp, vga_color);
          end
        end
        idx++;
      end else if (vga_color !== '0) begin
        report_mismatch($sformatf("frame%0d_blank", frame), 0, vga_color);
      end
      if (prev_hsync && !vga_scan.hsync) begin
        hsync_falls++;
      end
      prev_hsync = vga_scan.hsync;
      vsync_fell = prev_vsync && !vga_scan.vsync;
      prev_vsync = vga_scan.vsync;
    end
    if (!vsync_fell) begin
      report_failure($sformatf("timeout: frame %0d never reached its vsync pulse", frame));
    end else begin
      if (idx != N_PIX) begin
        report_mismatch($sformatf("frame%0d_visible_count", frame), N_PIX, idx);
      end
      // the first frame starts from the parked raster, later ones span every line
      if (frame > 1 && hsync_falls != V_TOTAL) begin
        report_mismatch($sformatf("frame%0d_hsync_count", frame), V_TOTAL, hsync_falls);
      end
    end
  endtask

  initial begin
    done       = 1'b0;
    mismatches = 0;
    failures   = 0;
    $readmemh("testbench/gfx_patterns.txt", patterns);
    build_image();
    check_reset();
    for (int f = 1; f <= N_FRAMES; f++) begin
      check_frame(f);
    end
    done = 1'b1;
  end

endmodule

/* testbench/tb_gfx_fade_display.sv */
module tb_gfx_fade_display;

  localparam int H_VISIBLE = 8;
  localparam int H_FRONT   = 2;
  localparam int H_SYNC    = 2;
  localparam int H_BACK    = 2;
  localparam int V_VISIBLE = 4;
  localparam int V_FRONT   = 1;
  localparam int V_SYNC    = 1;
  localparam int V_BACK    = 1;

  localparam int N_ENTRIES     = 10;
  localparam int N_FRAMES      = 6;
  localparam int FRAME_CYCLES  = (H_VISIBLE + H_FRONT + H_SYNC + H_BACK) *
                                 (V_VISIBLE + V_FRONT + V_SYNC + V_BACK);
  localparam int READY_TIMEOUT = 50;
  localparam int DONE_TIMEOUT  = (N_FRAMES + 4) * FRAME_CYCLES;

  logic                          clk;
  logic                          rst;
  logic                          gfx_valid;
  fb_pkg::gfx_cmd_t              gfx_cmd;
  logic                          gfx_ready;
  logic                          vga_enable;
  logic [fb_pkg::PIXEL_BITS-1:0] vga_color;
  fb_pkg::scan_t                 vga_scan;

  // x, y and color for each entry, three words per line of the file
  logic [fb_pkg::PIXEL_BITS-1:0] patterns [3*N_ENTRIES];
  int                            driver_errors;
  logic                          check_done;
  int                            mismatches;
  int                            failures;
  int                            waited;

  always #50 clk = ~clk;

  gfx_fade_display #(
    .H_VISIBLE(H_VISIBLE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_VISIBLE(V_VISIBLE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .gfx_valid (gfx_valid),
    .gfx_cmd   (gfx_cmd),
    .gfx_ready (gfx_ready),
    .vga_enable(vga_enable),
    .vga_color (vga_color),
    .vga_scan  (vga_scan)
  );

  tb_fade_checker #(
    .H_VISIBLE   (H_VISIBLE),
    .V_VISIBLE   (V_VISIBLE),
    .V_TOTAL     (V_VISIBLE + V_FRONT + V_SYNC + V_BACK),
    .N_ENTRIES   (N_ENTRIES),
    .FRAME_CYCLES(FRAME_CYCLES),
    .N_FRAMES    (N_FRAMES)
  ) u_checker (
    .clk       (clk),
    .gfx_ready (gfx_ready),
    .rst       (rst),
    .vga_color (vga_color),
    .vga_scan  (vga_scan),
    .done      (check_done),
    .mismatches(mismatches),
    .failures  (failures)
  );

  // called on a falling edge, returns on the falling edge after the handshake
  task automatic draw_pixel(input logic [fb_pkg::X_BITS-1:0] x,
                            input logic [fb_pkg::Y_BITS-1:0] y,
                            input logic [fb_pkg::PIXEL_BITS-1:0] color);
    int cycles;
    cycles        = 0;
    gfx_cmd.x     = x;
    gfx_cmd.y     = y;
    gfx_cmd.color = color;
    gfx_valid     = 1'b1;
    while (!gfx_ready && cycles < READY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!gfx_ready) begin
      $display("timeout: gfx_ready stayed low while drawing x %0d y %0d", x, y);
      driver_errors++;
    end
    @(negedge clk);
    gfx_valid = 1'b0;
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    gfx_valid     = 1'b0;
    gfx_cmd       = '0;
    vga_enable    = 1'b0;
    driver_errors = 0;
    $readmemh("testbench/gfx_patterns.txt", patterns);
    repeat (3) @(negedge clk);
    rst = 1'b0;
    // draw the whole image while the raster is parked
    for (int e = 0; e < N_ENTRIES; e++) begin
      draw_pixel(patterns[3*e][fb_pkg::X_BITS-1:0], patterns[3*e+1][fb_pkg::Y_BITS-1:0],
                 patterns[3*e+2]);
    end
    vga_enable = 1'b1;
    waited     = 0;
    while (!check_done && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!check_done) begin
      $display("timeout: the checker did not see all %0d frames", N_FRAMES);
      driver_errors++;
    end
    $display("errors: %0d mismatches, %0d checker failures, %0d driver failures",
             mismatches, failures, driver_errors);
    if (mismatches == 0 && failures == 0 && driver_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/fb_pkg.sv
src/raster_timing.sv
src/frame_buffer.sv
src/scanout.sv
src/fade_stage.sv
src/fb_write_arbiter.sv
src/gfx_fade_display.sv
testbench/tb_fade_checker.sv
testbench/tb_gfx_fade_display.sv
